/* common/cpu_pkg.sv */
package cpu_pkg;

    // first instruction fetched after reset
    localparam logic [31:0] RESET_PC = 32'h1c000000;

    // sequencer states
    typedef enum logic [2:0] {
        ST_IF,
        ST_ID,
        ST_EXE,
        ST_MEM,
        ST_WB
    } cpu_state_e;

    // decoded instructions
    typedef enum logic [4:0] {
        OP_ADD_W,
        OP_SUB_W,
        OP_SLT,
        OP_SLTU,
        OP_NOR,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLLI_W,
        OP_SRLI_W,
        OP_SRAI_W,
        OP_ADDI_W,
        OP_LD_W,
        OP_ST_W,
        OP_JIRL,
        OP_B,
        OP_BL,
        OP_BEQ,
        OP_BNE,
        OP_LU12I_W,
        OP_INVALID
    } inst_op_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_NOR, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

endpackage

/* common/rf_if.sv */
`timescale 1ns/100ps

interface rf_if;
    logic [4:0]  raddr1;
    logic [4:0]  raddr2;
    logic [31:0] rdata1;
    logic [31:0] rdata2;
    logic        we;
    logic [4:0]  waddr;
    logic [31:0] wdata;

    modport core (
        output raddr1, raddr2, we, waddr, wdata,
        input  rdata1, rdata2
    );

    modport regfile (
        input  raddr1, raddr2, we, waddr, wdata,
        output rdata1, rdata2
    );

endinterface

/* core/decoder.sv */
`timescale 1ns/100ps

module decoder (
    input  logic [31:0]        inst,
    output cpu_pkg::inst_op_e  op,
    output cpu_pkg::alu_op_e   alu_op,
    output logic [4:0]         rd,
    output logic [4:0]         rj,
    output logic [4:0]         rk,
    output logic [31:0]        imm,
    output logic [31:0]        br_offs,
    output logic               src1_is_pc,
    output logic               src2_is_imm,
    output logic               src_reg_is_rd,
    output logic               dst_is_r1,
    output logic               gr_we
);

    assign rd = inst[4:0];
    assign rj = inst[9:5];
    assign rk = inst[14:10];

    // opcode match on the major and minor fields
    always_comb begin
        op = cpu_pkg::OP_INVALID;
        case (inst[31:26])
            6'h00: begin
                if (inst[25:22] == 4'h0 && inst[21:20] == 2'h1) begin
                    case (inst[19:15])
                        5'h00: op = cpu_pkg::OP_ADD_W;
                        5'h02: op = cpu_pkg::OP_SUB_W;
                        5'h04: op = cpu_pkg::OP_SLT;
                        5'h05: op = cpu_pkg::OP_SLTU;
                        5'h08: op = cpu_pkg::OP_NOR;
                        5'h09: op = cpu_pkg::OP_AND;
                        5'h0a: op = cpu_pkg::OP_OR;
                        5'h0b: op = cpu_pkg::OP_XOR;
                        default: op = cpu_pkg::OP_INVALID;
                    endcase
                end else if (inst[25:22] == 4'h1 && inst[21:20] == 2'h0) begin
                    case (inst[19:15])
                        5'h01: op = cpu_pkg::OP_SLLI_W;
                        5'h09: op = cpu_pkg::OP_SRLI_W;
                        5'h11: op = cpu_pkg::OP_SRAI_W;
                        default: op = cpu_pkg::OP_INVALID;
                    endcase
                end else if (inst[25:22] == 4'ha) begin
                    op = cpu_pkg::OP_ADDI_W;
                end
            end
            6'h05: if (!inst[25]) op = cpu_pkg::OP_LU12I_W;
            6'h0a: begin
                if (inst[25:22] == 4'h2)
                    op = cpu_pkg::OP_LD_W;
                else if (inst[25:22] == 4'h6)
                    op = cpu_pkg::OP_ST_W;
            end
            6'h13: op = cpu_pkg::OP_JIRL;
            6'h14: op = cpu_pkg::OP_B;
            6'h15: op = cpu_pkg::OP_BL;
            6'h16: op = cpu_pkg::OP_BEQ;
            6'h17: op = cpu_pkg::OP_BNE;
            default: op = cpu_pkg::OP_INVALID;
        endcase
    end

    always_comb begin
        case (op)
            cpu_pkg::OP_SUB_W:   alu_op = cpu_pkg::ALU_SUB;
            cpu_pkg::OP_SLT:     alu_op = cpu_pkg::ALU_SLT;
            cpu_pkg::OP_SLTU:    alu_op = cpu_pkg::ALU_SLTU;
            cpu_pkg::OP_NOR:     alu_op = cpu_pkg::ALU_NOR;
            cpu_pkg::OP_AND:     alu_op = cpu_pkg::ALU_AND;
            cpu_pkg::OP_OR:      alu_op = cpu_pkg::ALU_OR;
            cpu_pkg::OP_XOR:     alu_op = cpu_pkg::ALU_XOR;
            cpu_pkg::OP_SLLI_W:  alu_op = cpu_pkg::ALU_SLL;
            cpu_pkg::OP_SRLI_W:  alu_op = cpu_pkg::ALU_SRL;
            cpu_pkg::OP_SRAI_W:  alu_op = cpu_pkg::ALU_SRA;
            cpu_pkg::OP_LU12I_W: alu_op = cpu_pkg::ALU_LUI;
            default:             alu_op = cpu_pkg::ALU_ADD;
        endcase
    end

    // link instructions compute pc + 4 through the alu
    assign src1_is_pc = (op == cpu_pkg::OP_JIRL) || (op == cpu_pkg::OP_BL);
    assign src2_is_imm = op inside {cpu_pkg::OP_SLLI_W, cpu_pkg::OP_SRLI_W, cpu_pkg::OP_SRAI_W,
                                    cpu_pkg::OP_ADDI_W, cpu_pkg::OP_LD_W, cpu_pkg::OP_ST_W,
                                    cpu_pkg::OP_LU12I_W, cpu_pkg::OP_JIRL, cpu_pkg::OP_BL};
    assign src_reg_is_rd = op inside {cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE, cpu_pkg::OP_ST_W};
    assign dst_is_r1 = (op == cpu_pkg::OP_BL);
    assign gr_we = !(op inside {cpu_pkg::OP_ST_W, cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE,
                                cpu_pkg::OP_B, cpu_pkg::OP_INVALID});

    always_comb begin
        if (src1_is_pc)
            imm = 32'h4;
        else if (op == cpu_pkg::OP_LU12I_W)
            imm = {inst[24:5], 12'b0};
        else if (op inside {cpu_pkg::OP_SLLI_W, cpu_pkg::OP_SRLI_W, cpu_pkg::OP_SRAI_W})
            imm = {27'b0, inst[14:10]};
        else
            imm = {{20{inst[21]}}, inst[21:10]};
    end

    // si26 for b and bl, si16 otherwise
    assign br_offs = (op == cpu_pkg::OP_B || op == cpu_pkg::OP_BL) ?
                     {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0} :
                     {{14{inst[25]}}, inst[25:10], 2'b0};

endmodule

/* core/alu.sv */
`timescale 1ns/100ps

module alu (
    input  cpu_pkg::alu_op_e alu_op,
    input  logic [31:0]      alu_src1,
    input  logic [31:0]      alu_src2,
    output logic [31:0]      alu_result
);

    logic [4:0] shamt;

    assign shamt = alu_src2[4:0];

    always_comb begin
        case (alu_op)
            cpu_pkg::ALU_ADD:
                alu_result = alu_src1 + alu_src2;
            cpu_pkg::ALU_SUB:
                alu_result = alu_src1 - alu_src2;
            cpu_pkg::ALU_SLT:
                alu_result = {31'b0, $signed(alu_src1) < $signed(alu_src2)};
            cpu_pkg::ALU_SLTU:
                alu_result = {31'b0, alu_src1 < alu_src2};
            cpu_pkg::ALU_AND:
                alu_result = alu_src1 & alu_src2;
            cpu_pkg::ALU_NOR:
                alu_result = ~(alu_src1 | alu_src2);
            cpu_pkg::ALU_OR:
                alu_result = alu_src1 | alu_src2;
            cpu_pkg::ALU_XOR:
                alu_result = alu_src1 ^ alu_src2;
            cpu_pkg::ALU_SLL:
                alu_result = alu_src1 << shamt;
            cpu_pkg::ALU_SRL:
                alu_result = alu_src1 >> shamt;
            cpu_pkg::ALU_SRA:
                alu_result = $unsigned($signed(alu_src1) >>> shamt);
            // immediate already shifted by the decoder
            cpu_pkg::ALU_LUI:
                alu_result = alu_src2;
            default:
                alu_result = 32'b0;
        endcase
    end

endmodule

/* core/regfile.sv */
`timescale 1ns/100ps

module regfile (
    input logic   clk,
    rf_if.regfile rf
);

    // r0 has no storage
    logic [31:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (rf.we && rf.waddr != 5'd0) begin
            regs[rf.waddr] <= rf.wdata;
        end
    end

    always_comb begin
        if (rf.raddr1 == 5'd0)
            rf.rdata1 = 32'b0;
        else
            rf.rdata1 = regs[rf.raddr1];
    end

    always_comb begin
        if (rf.raddr2 == 5'd0)
            rf.rdata2 = 32'b0;
        else
            rf.rdata2 = regs[rf.raddr2];
    end

endmodule

/* core/cpu_control.sv */
`timescale 1ns/100ps

module cpu_control (
    input  logic                clk,
    input  logic                reset,
    input  cpu_pkg::inst_op_e   op,
    output cpu_pkg::cpu_state_e state
);

    cpu_pkg::cpu_state_e next_state;
    logic                id_only;
    logic                mem_op;

    // instructions that finish in ID
    assign id_only = op inside {cpu_pkg::OP_B, cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE,
                                cpu_pkg::OP_INVALID};

    assign mem_op = (op == cpu_pkg::OP_LD_W) || (op == cpu_pkg::OP_ST_W);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cpu_pkg::ST_IF;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        case (state)
            cpu_pkg::ST_IF: begin
                next_state = cpu_pkg::ST_ID;
            end
            cpu_pkg::ST_ID: begin
                if (id_only)
                    next_state = cpu_pkg::ST_IF;
                else
                    next_state = cpu_pkg::ST_EXE;
            end
            cpu_pkg::ST_EXE: begin
                if (mem_op)
                    next_state = cpu_pkg::ST_MEM;
                else
                    next_state = cpu_pkg::ST_WB;
            end
            cpu_pkg::ST_MEM: begin
                // stores retire here, loads still have to write back
                if (op == cpu_pkg::OP_LD_W)
                    next_state = cpu_pkg::ST_WB;
                else
                    next_state = cpu_pkg::ST_IF;
            end
            cpu_pkg::ST_WB: begin
                next_state = cpu_pkg::ST_IF;
            end
            default: begin
                next_state = cpu_pkg::ST_IF;
            end
        endcase
    end

endmodule

/* core/mycpu_top.sv */
`timescale 1ns/100ps

module mycpu_top (
    input  logic        clk,
    input  logic        reset,
    // instruction sram
    output logic        inst_sram_we,
    output logic [31:0] inst_sram_addr,
    output logic [31:0] inst_sram_wdata,
    input  logic [31:0] inst_sram_rdata,
    // data sram
    output logic        data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,
    // write-back trace
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    cpu_pkg::cpu_state_e state;
    cpu_pkg::inst_op_e   op;
    cpu_pkg::alu_op_e    alu_op;

    logic [31:0] pc;
    logic [31:0] ir;
    logic [31:0] result;
    logic [31:0] inst;
    logic [4:0]  rd, rj, rk, dest;
    logic [31:0] imm, br_offs;
    logic        src1_is_pc, src2_is_imm, src_reg_is_rd, dst_is_r1, gr_we;
    logic [31:0] alu_src1, alu_src2, alu_result;
    logic [31:0] seq_pc, next_pc, br_target, final_result;
    logic        br_taken, inst_done;

    rf_if rf_bus ();

    // the fetched word is only on the sram bus during ID
    assign inst = (state == cpu_pkg::ST_ID) ? inst_sram_rdata : ir;

    decoder u_decoder (
        .inst(inst), .op(op), .alu_op(alu_op), .rd(rd), .rj(rj), .rk(rk),
        .imm(imm), .br_offs(br_offs), .src1_is_pc(src1_is_pc),
        .src2_is_imm(src2_is_imm), .src_reg_is_rd(src_reg_is_rd),
        .dst_is_r1(dst_is_r1), .gr_we(gr_we)
    );

    cpu_control u_control (.clk(clk), .reset(reset), .op(op), .state(state));

    regfile u_regfile (.clk(clk), .rf(rf_bus.regfile));

    alu u_alu (.alu_op(alu_op), .alu_src1(alu_src1), .alu_src2(alu_src2),
               .alu_result(alu_result));

    assign rf_bus.raddr1 = rj;
    assign rf_bus.raddr2 = src_reg_is_rd ? rd : rk;
    assign alu_src1 = src1_is_pc ? pc : rf_bus.rdata1;
    assign alu_src2 = src2_is_imm ? imm : rf_bus.rdata2;

    // branch resolution, jirl is relative to rj
    assign seq_pc = pc + 32'd4;
    assign br_taken = (op == cpu_pkg::OP_BEQ && rf_bus.rdata1 == rf_bus.rdata2) ||
                      (op == cpu_pkg::OP_BNE && rf_bus.rdata1 != rf_bus.rdata2) ||
                      op inside {cpu_pkg::OP_B, cpu_pkg::OP_BL, cpu_pkg::OP_JIRL};
    assign br_target = (op == cpu_pkg::OP_JIRL) ? rf_bus.rdata1 + br_offs : pc + br_offs;
    assign next_pc = br_taken ? br_target : seq_pc;

    assign inst_done = (state == cpu_pkg::ST_WB) ||
                       (state == cpu_pkg::ST_MEM && op == cpu_pkg::OP_ST_W) ||
                       (state == cpu_pkg::ST_ID && op inside {cpu_pkg::OP_B, cpu_pkg::OP_BEQ,
                                                               cpu_pkg::OP_BNE,
                                                               cpu_pkg::OP_INVALID});

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= cpu_pkg::RESET_PC;
        end else if (inst_done) begin
            pc <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (state == cpu_pkg::ST_ID)
            ir <= inst_sram_rdata;
        if (state == cpu_pkg::ST_EXE)
            result <= alu_result;
    end

    assign inst_sram_we    = 1'b0;
    assign inst_sram_addr  = pc;
    assign inst_sram_wdata = 32'b0;

    assign data_sram_we    = (state == cpu_pkg::ST_MEM) && (op == cpu_pkg::OP_ST_W);
    assign data_sram_addr  = result;
    assign data_sram_wdata = rf_bus.rdata2;

    assign dest         = dst_is_r1 ? 5'd1 : rd;
    assign final_result = (op == cpu_pkg::OP_LD_W) ? data_sram_rdata : result;

    assign rf_bus.we    = (state == cpu_pkg::ST_WB) && gr_we;
    assign rf_bus.waddr = dest;
    assign rf_bus.wdata = final_result;

    assign debug_wb_pc       = pc;
    assign debug_wb_rf_we    = {4{rf_bus.we}};
    assign debug_wb_rf_wnum  = dest;
    assign debug_wb_rf_wdata = final_result;

endmodule

/* test/cpu_assert.sv */
`timescale 1ns/100ps

module cpu_assert (
    input logic                clk,
    input logic                reset,
    input logic                inst_sram_we,
    input logic                data_sram_we,
    input logic [3:0]          debug_wb_rf_we,
    input cpu_pkg::cpu_state_e state
);

    // store strobe is a single-cycle pulse
    store_pulse: assert property (@(posedge clk) disable iff (reset)
        data_sram_we |=> !data_sram_we)
        else $error("data_sram_we held for more than one cycle");

    no_inst_write: assert property (@(posedge clk) !inst_sram_we)
        else $error("inst_sram_we went high");

    trace_we_shape: assert property (@(posedge clk) disable iff (reset)
        debug_wb_rf_we == 4'h0 || debug_wb_rf_we == 4'hf)
        else $error("debug_wb_rf_we is neither 0 nor f");

    quiet_after_reset: assert property (@(posedge clk)
        reset |=> (!data_sram_we && !inst_sram_we && debug_wb_rf_we == 4'h0 &&
                   state == cpu_pkg::ST_IF))
        else $error("strobe active or state not IF after reset");

endmodule

bind mycpu_top cpu_assert i_assert (
    .clk(clk), .reset(reset), .inst_sram_we(inst_sram_we), .data_sram_we(data_sram_we),
    .debug_wb_rf_we(debug_wb_rf_we), .state(state)
);

/* test/tb_cpu.sv */
`timescale 1ns/100ps

module tb_cpu;

    logic        clk;
    logic        reset;
    logic [31:0] inst_sram_rdata;
    logic [31:0] data_sram_rdata;
    logic        inst_sram_we;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic        data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    // word-addressed models, 4 KB each
    logic [31:0] imem [0:1023];
    logic [31:0] dmem [0:1023];
    logic [31:0] inst_addr_q;
    logic [31:0] data_addr_q;

    // expected write-back trace and final memory contents
    string       t_name [$];
    logic [31:0] t_pc [$];
    logic [4:0]  t_wnum [$];
    logic [31:0] t_wdata [$];
    logic [31:0] m_addr [$];
    logic [31:0] m_data [$];

    int n_words = 0;
    int t_idx = 0;
    int pass_count = 0;
    int fail_count = 0;
    int cycles = 0;
    int cycle_limit = 1000;

    mycpu_top i_dut (
        .clk(clk), .reset(reset),
        .inst_sram_we(inst_sram_we), .inst_sram_addr(inst_sram_addr),
        .inst_sram_wdata(inst_sram_wdata), .inst_sram_rdata(inst_sram_rdata),
        .data_sram_we(data_sram_we), .data_sram_addr(data_sram_addr),
        .data_sram_wdata(data_sram_wdata), .data_sram_rdata(data_sram_rdata),
        .debug_wb_pc(debug_wb_pc), .debug_wb_rf_we(debug_wb_rf_we),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    always #5 clk = ~clk;

    function automatic int imem_index(logic [31:0] addr);
        logic [31:0] offs;
        offs = addr - cpu_pkg::RESET_PC;
        return int'(offs[11:2]);
    endfunction

    // address sampled at the rising edge and data driven at the falling edge
    always @(posedge clk) begin
        inst_addr_q <= inst_sram_addr;
        data_addr_q <= data_sram_addr;
        if (data_sram_we)
            dmem[data_sram_addr[11:2]] <= data_sram_wdata;
        // the core never writes its instruction memory
        if (inst_sram_we) begin
            $display("instruction sram written at %h with %h", inst_sram_addr,
                     inst_sram_wdata);
            fail_count++;
        end
    end

    always @(negedge clk) begin
        inst_sram_rdata <= imem[imem_index(inst_addr_q)];
        data_sram_rdata <= dmem[data_addr_q[11:2]];
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d trace entries never seen",
                     cycles, t_name.size() - t_idx);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic load_vectors();
        int          fd;
        int          code;
        string       line;
        string       kind;
        string       name;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        fd = $fopen("test/cpu_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/cpu_vectors.txt");
            fail_count++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0 || line.len() < 2 || line.substr(0, 0) == "#")
                continue;
            code = $sscanf(line, "%s", kind);
            if (kind == "P") begin
                code = $sscanf(line, "%s %h %h", kind, a, b);
                imem[imem_index(a)] = b;
                n_words++;
            end else if (kind == "T") begin
                code = $sscanf(line, "%s %s %h %h %h", kind, name, a, b, c);
                t_name.push_back(name);
                t_pc.push_back(a);
                t_wnum.push_back(b[4:0]);
                t_wdata.push_back(c);
            end else if (kind == "M") begin
                code = $sscanf(line, "%s %h %h", kind, a, b);
                m_addr.push_back(a);
                m_data.push_back(b);
            end
        end
        $fclose(fd);
    endtask

    task automatic check_writeback();
        if (t_idx >= t_name.size()) begin
            $display("unexpected write-back at pc %h to r%0d", debug_wb_pc, debug_wb_rf_wnum);
            fail_count++;
            return;
        end
        if (debug_wb_pc != t_pc[t_idx] || debug_wb_rf_wnum != t_wnum[t_idx] ||
            debug_wb_rf_wdata != t_wdata[t_idx]) begin
            $display("[FAIL] %s expected pc %h r%0d %h actual pc %h r%0d %h",
                     t_name[t_idx], t_pc[t_idx], t_wnum[t_idx], t_wdata[t_idx],
                     debug_wb_pc, debug_wb_rf_wnum, debug_wb_rf_wdata);
            fail_count++;
        end else begin
            $display("[PASS] %s", t_name[t_idx]);
            pass_count++;
        end
        t_idx++;
    endtask

    always @(posedge clk) begin
        if (!reset && debug_wb_rf_we != 4'h0)
            check_writeback();
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        inst_sram_rdata = 32'b0;
        data_sram_rdata = 32'b0;
        // top opcode 6'h3f decodes as invalid
        for (int i = 0; i < 1024; i++) begin
            imem[i] = {22'h3fffff, i[9:0]};
            dmem[i] = {20'hd0d0d, i[9:0], 2'b00};
        end
        load_vectors();
        cycle_limit = 5 * n_words + 100;
        if (t_name.size() == 0) begin
            $display("no expected trace entries were loaded");
            fail_count++;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        wait (t_idx >= t_name.size());
        // room for any write-back that should not happen
        repeat (20) @(posedge clk);
        for (int i = 0; i < m_addr.size(); i++) begin
            if (dmem[m_addr[i][11:2]] != m_data[i]) begin
                $display("[FAIL] mem_%h expected %h actual %h", m_addr[i], m_data[i],
                         dmem[m_addr[i][11:2]]);
                fail_count++;
            end else begin
                $display("[PASS] mem_%h", m_addr[i]);
                pass_count++;
            end
        end
        $display("passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

/* test/cpu_vectors.txt */
# P address word : program word at a byte address
# T name pc wnum wdata : expected write-back, M address word : data memory at the end
P 1c000000 02801401
P 1c000004 02bff402
P 1c000008 00100823
P 1c00000c 00110824
P 1c000010 00120445
P 1c000014 00128446
P 1c000018 00140827
P 1c00001c 00148828
P 1c000020 00150829
P 1c000024 0015882a
P 1c000028 0040904b
P 1c00002c 0044904c
P 1c000030 0048844d
P 1c000034 142468ae
P 1c000038 0299e1ce
P 1c00003c 0284000f
P 1c000040 298011ee
P 1c000044 288011f0
P 1c000048 58000823
P 1c00004c 02800411
P 1c000050 5c000823
P 1c000054 02800811
P 1c000058 58000a0e
P 1c00005c 02800c11
P 1c000060 5c000821
P 1c000064 50000800
P 1c000068 02801011
P 1c00006c 02801c12
P 1c000070 54000c00
P 1c000074 02801411
P 1c000078 02801811
P 1c00007c 14380013
P 1c000080 4c009274
P 1c000084 02801c11
P 1c000088 02802011
P 1c00008c 02802411
P 1c000090 02802400
P 1c000094 00100015
P 1c000098 50000000
T addi_pos 1c000000 01 00000005
T addi_neg 1c000004 02 fffffffd
T add_w 1c000008 03 00000002
T sub_w 1c00000c 04 00000008
T slt 1c000010 05 00000001
T sltu 1c000014 06 00000000
T nor 1c000018 07 00000002
T and 1c00001c 08 00000005
T or 1c000020 09 fffffffd
T xor 1c000024 0a fffffff8
T slli_w 1c000028 0b ffffffd0
T srli_w 1c00002c 0c 0fffffff
T srai_w 1c000030 0d fffffffe
T lu12i_w 1c000034 0e 12345000
T addi_low 1c000038 0e 12345678
T addi_base 1c00003c 0f 00000100
T ld_w 1c000044 10 12345678
T beq_not_taken 1c00004c 11 00000001
T branch_chain 1c00006c 12 00000007
T bl_link 1c000070 01 1c000074
T lu12i_base 1c00007c 13 1c000000
T jirl_link 1c000080 14 1c000084
T r0_write 1c000090 00 00000009
T r0_read 1c000094 15 00000000
M 00000104 12345678

/* compile.f */
common/cpu_pkg.sv
common/rf_if.sv
core/decoder.sv
core/alu.sv
core/regfile.sv
core/cpu_control.sv
core/mycpu_top.sv
test/cpu_assert.sv
test/tb_cpu.sv
